/* Makefile */
TOP := tb_axi_axil_wr

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "Some tests failed" sim.log || ! grep -q "All tests passed" sim.log; then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

/* bench/tb_axi_axil_wr.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_axi_axil_wr
  import axi_pkg::*;
();

  localparam int OUTSTANDING_W = 2;
  localparam int MAX_OUT       = 1 << OUTSTANDING_W;
  localparam int NUM_WR        = 200;
  localparam int RST_CYCLES    = 16;
  localparam int TIMEOUT_CYC   = NUM_WR * 30 + RST_CYCLES;

  logic   clk;
  logic   i_rst;

  // AXI side
  logic   s_awvalid;
  logic   s_awready;
  addr_t  s_awaddr;
  id_t    s_awid;
  len_t   s_awlen;
  size_t  s_awsize;
  burst_t s_awburst;
  user_t  s_awuser;
  logic   s_wvalid;
  logic   s_wready;
  data_t  s_wdata;
  strb_t  s_wstrb;
  logic   s_wlast;
  logic   s_bvalid;
  logic   s_bready;
  id_t    s_bid;
  resp_t  s_bresp;
  user_t  s_buser;

  // AXI-Lite side
  logic   m_awvalid;
  logic   m_awready;
  addr_t  m_awaddr;
  logic   m_wvalid;
  logic   m_wready;
  data_t  m_wdata;
  strb_t  m_wstrb;
  logic   m_bvalid;
  logic   m_bready;
  resp_t  m_bresp;

  // Pre-generated writes
  addr_t  wr_addr [NUM_WR];
  id_t    wr_id   [NUM_WR];
  user_t  wr_user [NUM_WR];
  data_t  wr_data [NUM_WR];
  strb_t  wr_strb [NUM_WR];

  // Scoreboards
  addr_t  aw_q [$];
  data_t  w_data_q [$];
  strb_t  w_strb_q [$];
  id_t    bid_q [$];
  user_t  buser_q [$];
  resp_t  bresp_q [$];

  // Expected heads, as seen at the next edge
  logic   aw_head_vld;
  addr_t  aw_head;
  logic   w_head_vld;
  data_t  w_head_data;
  strb_t  w_head_strb;
  logic   b_head_vld;
  id_t    b_head_id;
  user_t  b_head_user;
  resp_t  b_head_resp;

  int     aw_acc_cnt;
  int     w_acc_cnt;
  int     b_cnt;
  int     outstanding;
  int     cycle_cnt;
  logic   stim_started;
  logic   b_stall;

  assign outstanding = aw_acc_cnt - b_cnt;

  axi_axil_wr_top #(
    .OUTSTANDING_W(OUTSTANDING_W)
  ) u_dut (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_s_awvalid (s_awvalid),
    .o_s_awready (s_awready),
    .i_s_awaddr  (s_awaddr),
    .i_s_awid    (s_awid),
    .i_s_awlen   (s_awlen),
    .i_s_awsize  (s_awsize),
    .i_s_awburst (s_awburst),
    .i_s_awuser  (s_awuser),
    .i_s_wvalid  (s_wvalid),
    .o_s_wready  (s_wready),
    .i_s_wdata   (s_wdata),
    .i_s_wstrb   (s_wstrb),
    .i_s_wlast   (s_wlast),
    .o_s_bvalid  (s_bvalid),
    .i_s_bready  (s_bready),
    .o_s_bid     (s_bid),
    .o_s_bresp   (s_bresp),
    .o_s_buser   (s_buser),
    .o_m_awvalid (m_awvalid),
    .i_m_awready (m_awready),
    .o_m_awaddr  (m_awaddr),
    .o_m_wvalid  (m_wvalid),
    .i_m_wready  (m_wready),
    .o_m_wdata   (m_wdata),
    .o_m_wstrb   (m_wstrb),
    .i_m_bvalid  (m_bvalid),
    .o_m_bready  (m_bready),
    .i_m_bresp   (m_bresp)
  );

  tb_axil_sub u_sub (
    .clk       (clk),
    .i_rst     (i_rst),
    .i_awvalid (m_awvalid),
    .o_awready (m_awready),
    .i_awaddr  (m_awaddr),
    .i_wvalid  (m_wvalid),
    .o_wready  (m_wready),
    .o_bvalid  (m_bvalid),
    .i_bready  (m_bready),
    .o_bresp   (m_bresp)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  task automatic stop_run(input string what);
    $display("%s", what);
    $display("Some tests failed");
    $fatal(1, "run stopped");
  endtask

  task automatic drive_aw_channel();
    int gap;
    for (int i = 0; i < NUM_WR; i++) begin
      gap = $urandom % 3;
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
      // At most three addresses ahead of data, else a full ID FIFO blocks W
      while (i >= w_acc_cnt + MAX_OUT - 1) begin
        @(posedge clk);
        #1;
      end
      s_awvalid = 1'b1;
      s_awaddr  = wr_addr[i];
      s_awid    = wr_id[i];
      s_awuser  = wr_user[i];
      @(posedge clk);
      while (!s_awready) begin
        @(posedge clk);
      end
      #1;
      s_awvalid = 1'b0;
    end
  endtask

  task automatic drive_w_channel();
    int gap;
    for (int i = 0; i < NUM_WR; i++) begin
      gap = $urandom % 4;
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
      s_wvalid = 1'b1;
      s_wdata  = wr_data[i];
      s_wstrb  = wr_strb[i];
      @(posedge clk);
      while (!s_wready) begin
        @(posedge clk);
      end
      #1;
      s_wvalid = 1'b0;
    end
  endtask

  // B back-pressure with long stall stretches
  always begin
    @(posedge clk);
    #1;
    if (i_rst) begin
      s_bready = 1'b0;
    end else begin
      if (($urandom % 8) == 0) begin
        b_stall = !b_stall;
      end
      s_bready = !b_stall && (($urandom % 4) != 0);
    end
  end

  // Scoreboard bookkeeping, pops before pushes
  always @(posedge clk) begin
    if (!i_rst) begin
      if (m_awvalid && m_awready && aw_q.size() > 0) begin
        void'(aw_q.pop_front());
      end
      if (m_wvalid && m_wready && w_data_q.size() > 0) begin
        void'(w_data_q.pop_front());
        void'(w_strb_q.pop_front());
      end
      if (s_bvalid && s_bready) begin
        if (bid_q.size() > 0) begin
          void'(bid_q.pop_front());
          void'(buser_q.pop_front());
          void'(bresp_q.pop_front());
        end
        b_cnt <= b_cnt + 1;
      end
      if (s_awvalid && s_awready) begin
        aw_q.push_back(s_awaddr);
        bid_q.push_back(s_awid);
        buser_q.push_back(s_awuser);
        bresp_q.push_back(s_awaddr[15] ? RESP_SLVERR : RESP_OKAY);
        aw_acc_cnt <= aw_acc_cnt + 1;
      end
      if (s_wvalid && s_wready) begin
        w_data_q.push_back(s_wdata);
        w_strb_q.push_back(s_wstrb);
        w_acc_cnt <= w_acc_cnt + 1;
      end
    end
    aw_head_vld <= aw_q.size() > 0;
    aw_head     <= aw_q.size() > 0 ? aw_q[0] : '0;
    w_head_vld  <= w_data_q.size() > 0;
    w_head_data <= w_data_q.size() > 0 ? w_data_q[0] : '0;
    w_head_strb <= w_strb_q.size() > 0 ? w_strb_q[0] : '0;
    b_head_vld  <= bid_q.size() > 0;
    b_head_id   <= bid_q.size() > 0 ? bid_q[0] : '0;
    b_head_user <= buser_q.size() > 0 ? buser_q[0] : '0;
    b_head_resp <= bresp_q.size() > 0 ? bresp_q[0] : RESP_OKAY;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYC) begin
      stop_run($sformatf("Run timed out after %0d cycles with %0d of %0d writes answered",
                         cycle_cnt, b_cnt, NUM_WR));
    end
  end

  a_idle_after_reset: assert property (
    @(posedge clk) disable iff (i_rst)
    !stim_started |-> !m_awvalid && !m_wvalid && !s_bvalid
  ) else stop_run($sformatf("Fail at %0d ns: output valid before any stimulus", $time));

  a_m_aw_order: assert property (
    @(posedge clk) disable iff (i_rst)
    m_awvalid && m_awready |-> aw_head_vld && m_awaddr == aw_head
  ) else stop_run($sformatf("Fail at %0d ns: AXI-Lite address %h wrong", $time, m_awaddr));

  a_m_w_order: assert property (
    @(posedge clk) disable iff (i_rst)
    m_wvalid && m_wready |-> w_head_vld && m_wdata == w_head_data && m_wstrb == w_head_strb
  ) else stop_run($sformatf("Fail at %0d ns: AXI-Lite data %h wrong", $time, m_wdata));

  a_s_b_match: assert property (
    @(posedge clk) disable iff (i_rst)
    s_bvalid && s_bready |->
      b_head_vld && s_bid == b_head_id && s_buser == b_head_user && s_bresp == b_head_resp
  ) else stop_run($sformatf("Fail at %0d ns: B id %h user %h resp %h wrong",
                            $time, s_bid, s_buser, s_bresp));

  a_outstanding_limit: assert property (
    @(posedge clk) disable iff (i_rst)
    outstanding <= MAX_OUT
  ) else stop_run($sformatf("Fail at %0d ns: %0d writes outstanding", $time, outstanding));

  a_full_blocks: assert property (
    @(posedge clk) disable iff (i_rst)
    outstanding == MAX_OUT |-> !s_awready && !s_wready
  ) else stop_run($sformatf("Fail at %0d ns: ready high at outstanding limit", $time));

  a_b_hold: assert property (
    @(posedge clk) disable iff (i_rst)
    s_bvalid && !s_bready |=> s_bvalid && $stable(s_bid) && $stable(s_bresp)
  ) else stop_run($sformatf("Fail at %0d ns: stalled B changed", $time));

  a_b_backpressure: assert property (
    @(posedge clk) disable iff (i_rst)
    s_bvalid && !s_bready |-> !m_bready
  ) else stop_run($sformatf("Fail at %0d ns: AXI-Lite bready high while B stalled", $time));

  initial begin
    i_rst        = 1'b1;
    s_awvalid    = 1'b0;
    s_awaddr     = '0;
    s_awid       = '0;
    s_awlen      = '0;
    s_awsize     = 3'd2;
    s_awburst    = BURST_FIXED;
    s_awuser     = '0;
    s_wvalid     = 1'b0;
    s_wdata      = '0;
    s_wstrb      = '0;
    s_wlast      = 1'b1;
    s_bready     = 1'b0;
    b_stall      = 1'b0;
    stim_started = 1'b0;
    aw_acc_cnt   = 0;
    w_acc_cnt    = 0;
    b_cnt        = 0;
    cycle_cnt    = 0;

    void'($urandom(32'h7cbb));
    for (int i = 0; i < NUM_WR; i++) begin
      wr_addr[i] = addr_t'($urandom);
      wr_id[i]   = id_t'($urandom);
      wr_user[i] = user_t'($urandom);
      wr_data[i] = $urandom;
      wr_strb[i] = strb_t'($urandom);
    end

    repeat (RST_CYCLES) @(posedge clk);
    #1;
    i_rst = 1'b0;

    // A few idle cycles so the post-reset check sees quiet outputs
    repeat (4) @(posedge clk);
    #1;
    stim_started = 1'b1;
    fork
      drive_aw_channel();
      drive_w_channel();
    join

    while (b_cnt < NUM_WR) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);

    if (aw_q.size() == 0 && w_data_q.size() == 0 && bid_q.size() == 0 &&
        w_acc_cnt == NUM_WR) begin
      $display("All tests passed");
      $finish;
    end else begin
      stop_run("Writes were left unmatched in the scoreboard at the end of the run");
    end
  end

endmodule

`default_nettype wire

/* bench/tb_axil_sub.sv */
`timescale 1ns/1ps
`default_nettype none

// AXI-Lite subordinate model, answers writes in order once address and data are in
module tb_axil_sub
  import axi_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  i_rst,
  input  wire logic  i_awvalid,
  output logic       o_awready,
  input  wire addr_t i_awaddr,
  input  wire logic  i_wvalid,
  output logic       o_wready,
  output logic       o_bvalid,
  input  wire logic  i_bready,
  output resp_t      o_bresp
);

  // Address bit 15 of every address not yet paired with data
  logic  err_q [$];
  resp_t resp_q [$];
  int    w_pending;
  logic  aw_hs;
  logic  w_hs;
  logic  b_hs;
  logic  aw_err;

  initial begin
    o_awready = 1'b0;
    o_wready  = 1'b0;
    o_bvalid  = 1'b0;
    o_bresp   = RESP_OKAY;
    w_pending = 0;
  end

  always begin
    @(posedge clk);
    aw_hs  = i_awvalid && o_awready;
    w_hs   = i_wvalid && o_wready;
    b_hs   = o_bvalid && i_bready;
    aw_err = i_awaddr[15];
    #1;
    if (i_rst) begin
      err_q.delete();
      resp_q.delete();
      w_pending = 0;
      o_awready = 1'b0;
      o_wready  = 1'b0;
      o_bvalid  = 1'b0;
    end else begin
      if (aw_hs) begin
        err_q.push_back(aw_err);
      end
      if (w_hs) begin
        w_pending++;
      end
      if (b_hs) begin
        o_bvalid = 1'b0;
      end
      // Pair addresses with data in arrival order
      while (err_q.size() > 0 && w_pending > 0) begin
        resp_q.push_back(err_q.pop_front() ? RESP_SLVERR : RESP_OKAY);
        w_pending--;
      end
      // Random delay before each response
      if (!o_bvalid && resp_q.size() > 0 && ($urandom % 3) != 0) begin
        o_bvalid = 1'b1;
        o_bresp  = resp_q.pop_front();
      end
      o_awready = ($urandom % 4) != 0;
      o_wready  = ($urandom % 4) != 0;
    end
  end

endmodule

`default_nettype wire

/* design/axi_axil_wr_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_axil_wr_ctrl
  import axi_pkg::*;
  import bridge_pkg::*;
(
  input  wire logic   clk,
  input  wire logic   i_rst,

  // AXI AW and W handshake and burst fields
  input  wire logic   i_awvalid,
  output logic        o_awready,
  input  wire len_t   i_awlen,
  input  wire size_t  i_awsize,
  input  wire burst_t i_awburst,
  input  wire logic   i_wvalid,
  output logic        o_wready,
  input  wire logic   i_wlast,

  // AXI B
  output logic        o_bvalid,
  output resp_t       o_bresp,
  input  wire logic   i_bready,

  // Skid buffer space and accept strobes
  input  wire logic   i_aw_sb_ready,
  output logic        o_aw_sb_push,
  input  wire logic   i_w_sb_ready,
  output logic        o_w_sb_push,

  // AXI-Lite B
  input  wire logic   i_axil_bvalid,
  input  wire resp_t  i_axil_bresp,
  output logic        o_axil_bready,

  // ID capture and reflection
  input  wire id_t    i_awid,
  input  wire user_t  i_awuser,
  output id_t         o_bid,
  output user_t       o_buser,

  id_fifo_if.producer idq_prod,
  id_fifo_if.consumer idq_cons
);

  logic aw_hs;
  logic w_hs;
  logic b_hs;

  // Accept only with buffer space and a free ID slot
  assign o_awready = i_aw_sb_ready && !idq_prod.full;
  assign o_wready  = i_w_sb_ready && !idq_prod.full;

  assign aw_hs = i_awvalid && o_awready;
  assign w_hs  = i_wvalid && o_wready;
  assign b_hs  = o_bvalid && i_bready;

  assign o_aw_sb_push = aw_hs;
  assign o_w_sb_push  = w_hs;

  // Every accepted address records its ID for the matching B
  assign idq_prod.push      = aw_hs;
  assign idq_prod.push_data = id_entry_t'{id: i_awid, user: i_awuser};

  // B passes straight across, ID comes from the oldest entry
  assign o_bvalid      = i_axil_bvalid;
  assign o_bresp       = i_axil_bresp;
  assign o_axil_bready = i_bready;
  assign o_bid         = idq_cons.pop_data.id;
  assign o_buser       = idq_cons.pop_data.user;

  assign idq_cons.pop = b_hs;

  // Only single-beat fixed bursts within the bus width are supported
  a_single_beat_aw: assert property (
    @(posedge clk) disable iff (i_rst)
    aw_hs |-> i_awlen == '0 && i_awburst == BURST_FIXED && i_awsize <= MAX_SIZE
  ) else $error("ctrl: unsupported AW burst");

  a_single_beat_w: assert property (
    @(posedge clk) disable iff (i_rst)
    w_hs |-> i_wlast
  ) else $error("ctrl: W beat without wlast");

  // A response with nothing outstanding means the ID tracking is lost
  a_b_has_id: assert property (
    @(posedge clk) disable iff (i_rst)
    i_axil_bvalid |-> !idq_cons.empty
  ) else $error("ctrl: AXI-Lite B with empty ID FIFO");

endmodule

`default_nettype wire

/* design/axi_axil_wr_top.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_axil_wr_top
  import axi_pkg::*;
#(
  parameter int OUTSTANDING_W = 2
) (
  input  wire logic   clk,
  input  wire logic   i_rst,

  // AXI subordinate AW
  input  wire logic   i_s_awvalid,
  output logic        o_s_awready,
  input  wire addr_t  i_s_awaddr,
  input  wire id_t    i_s_awid,
  input  wire len_t   i_s_awlen,
  input  wire size_t  i_s_awsize,
  input  wire burst_t i_s_awburst,
  input  wire user_t  i_s_awuser,

  // AXI subordinate W
  input  wire logic   i_s_wvalid,
  output logic        o_s_wready,
  input  wire data_t  i_s_wdata,
  input  wire strb_t  i_s_wstrb,
  input  wire logic   i_s_wlast,

  // AXI subordinate B
  output logic        o_s_bvalid,
  input  wire logic   i_s_bready,
  output id_t         o_s_bid,
  output resp_t       o_s_bresp,
  output user_t       o_s_buser,

  // AXI-Lite manager AW and W
  output logic        o_m_awvalid,
  input  wire logic   i_m_awready,
  output addr_t       o_m_awaddr,
  output logic        o_m_wvalid,
  input  wire logic   i_m_wready,
  output data_t       o_m_wdata,
  output strb_t       o_m_wstrb,

  // AXI-Lite manager B
  input  wire logic   i_m_bvalid,
  output logic        o_m_bready,
  input  wire resp_t  i_m_bresp
);

  localparam int unsigned AW_SB_W = $bits(addr_t);
  localparam int unsigned W_SB_W  = $bits(data_t) + $bits(strb_t);

  logic              aw_sb_ready;
  logic              aw_sb_push;
  logic              w_sb_ready;
  logic              w_sb_push;
  logic [W_SB_W-1:0] w_sb_data;

  // Strobes ride above the data in the W buffer
  assign {o_m_wstrb, o_m_wdata} = w_sb_data;

  id_fifo_if #(
    .OUTSTANDING_W(OUTSTANDING_W)
  ) u_idq ();

  axi_axil_wr_ctrl u_ctrl (
    .clk           (clk),
    .i_rst         (i_rst),
    .i_awvalid     (i_s_awvalid),
    .o_awready     (o_s_awready),
    .i_awlen       (i_s_awlen),
    .i_awsize      (i_s_awsize),
    .i_awburst     (i_s_awburst),
    .i_wvalid      (i_s_wvalid),
    .o_wready      (o_s_wready),
    .i_wlast       (i_s_wlast),
    .o_bvalid      (o_s_bvalid),
    .o_bresp       (o_s_bresp),
    .i_bready      (i_s_bready),
    .i_aw_sb_ready (aw_sb_ready),
    .o_aw_sb_push  (aw_sb_push),
    .i_w_sb_ready  (w_sb_ready),
    .o_w_sb_push   (w_sb_push),
    .i_axil_bvalid (i_m_bvalid),
    .i_axil_bresp  (i_m_bresp),
    .o_axil_bready (o_m_bready),
    .i_awid        (i_s_awid),
    .i_awuser      (i_s_awuser),
    .o_bid         (o_s_bid),
    .o_buser       (o_s_buser),
    .idq_prod      (u_idq.producer),
    .idq_cons      (u_idq.consumer)
  );

  skid_buf #(
    .DATA_W(AW_SB_W)
  ) u_aw_sb (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_valid (aw_sb_push),
    .i_data  (i_s_awaddr),
    .o_ready (aw_sb_ready),
    .o_valid (o_m_awvalid),
    .o_data  (o_m_awaddr),
    .i_ready (i_m_awready)
  );

  skid_buf #(
    .DATA_W(W_SB_W)
  ) u_w_sb (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_valid (w_sb_push),
    .i_data  ({i_s_wstrb, i_s_wdata}),
    .o_ready (w_sb_ready),
    .o_valid (o_m_wvalid),
    .o_data  (w_sb_data),
    .i_ready (i_m_wready)
  );

  id_fifo #(
    .OUTSTANDING_W(OUTSTANDING_W)
  ) u_id_fifo (
    .clk   (clk),
    .i_rst (i_rst),
    .fifo  (u_idq.fifo)
  );

endmodule

`default_nettype wire

/* design/axi_pkg.sv */
`default_nettype none

package axi_pkg;

  // Bus field widths for the 32-bit data, 16-bit address system
  typedef logic [15:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [3:0]  id_t;
  typedef logic [1:0]  user_t;
  typedef logic [1:0]  resp_t;
  typedef logic [7:0]  len_t;
  typedef logic [2:0]  size_t;
  typedef logic [1:0]  burst_t;

  // B response codes
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // Burst type codes
  localparam burst_t BURST_FIXED = 2'b00;
  localparam burst_t BURST_INCR  = 2'b01;

endpackage

`default_nettype wire

/* design/bridge_pkg.sv */
`default_nettype none

package bridge_pkg;

  // One outstanding write as seen from the AXI side
  typedef struct packed {
    axi_pkg::id_t   id;
    axi_pkg::user_t user;
  } id_entry_t;

  // Largest beat size a 32-bit data bus can carry, 4 bytes
  localparam axi_pkg::size_t MAX_SIZE =
      axi_pkg::size_t'($clog2($bits(axi_pkg::data_t) / 8));

endpackage

`default_nettype wire

/* design/id_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module id_fifo
  import bridge_pkg::*;
#(
  parameter int OUTSTANDING_W = 2
) (
  input wire logic clk,
  input wire logic i_rst,
  id_fifo_if.fifo  fifo
);

  localparam int DEPTH = 1 << OUTSTANDING_W;

  // Pointers carry one extra wrap bit
  typedef logic [OUTSTANDING_W:0]   ptr_t;
  typedef logic [OUTSTANDING_W-1:0] idx_t;

  id_entry_t mem [DEPTH];
  ptr_t      wr_ptr;
  ptr_t      rd_ptr;
  idx_t      wr_idx;
  idx_t      rd_idx;

  assign wr_idx = wr_ptr[OUTSTANDING_W-1:0];
  assign rd_idx = rd_ptr[OUTSTANDING_W-1:0];

  always_ff @(posedge clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (fifo.push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (fifo.pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fifo.push) begin
      mem[wr_idx] <= fifo.push_data;
    end
  end

  // Occupancy and status
  assign fifo.level    = wr_ptr - rd_ptr;
  assign fifo.full     = fifo.level == ptr_t'(DEPTH);
  assign fifo.empty    = fifo.level == '0;

  // Head shows without a read cycle
  assign fifo.pop_data = mem[rd_idx];

  a_no_overflow: assert property (
    @(posedge clk) disable iff (i_rst)
    fifo.push |-> !fifo.full
  ) else $error("id_fifo: push while full");

  a_no_underflow: assert property (
    @(posedge clk) disable iff (i_rst)
    fifo.pop |-> !fifo.empty
  ) else $error("id_fifo: pop while empty");

endmodule

`default_nettype wire

/* design/id_fifo_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface id_fifo_if
  import bridge_pkg::*;
#(
  parameter int OUTSTANDING_W = 2
);

  // Write side
  logic      push;
  id_entry_t push_data;
  logic      full;

  // Read side, head entry is valid whenever empty is low
  logic      pop;
  id_entry_t pop_data;
  logic      empty;

  // Number of entries held
  logic [OUTSTANDING_W:0] level;

  modport producer (
    output push,
    output push_data,
    input  full
  );

  modport consumer (
    output pop,
    input  pop_data,
    input  empty
  );

  modport fifo (
    input  push,
    input  push_data,
    input  pop,
    output pop_data,
    output full,
    output empty,
    output level
  );

endinterface

`default_nettype wire

/* design/skid_buf.sv */
`timescale 1ns/1ps
`default_nettype none

module skid_buf #(
  parameter int unsigned DATA_W = 16
) (
  input  wire logic              clk,
  input  wire logic              i_rst,

  // Upstream, i_valid is an accept strobe
  input  wire logic              i_valid,
  input  wire logic [DATA_W-1:0] i_data,
  output logic                   o_ready,

  // Downstream, registered
  output logic                   o_valid,
  output logic [DATA_W-1:0]      o_data,
  input  wire logic              i_ready
);

  logic              skid_valid;
  logic [DATA_W-1:0] skid_data;
  logic              out_free;
  logic              to_skid;

  // Output register can take a new word this cycle
  assign out_free = !o_valid || i_ready;

  // Incoming word lands in the spare entry when the output is stalled
  assign to_skid  = i_valid && !out_free;

  // Space is left unless the spare entry is occupied
  assign o_ready  = !skid_valid;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_valid    <= 1'b0;
      skid_valid <= 1'b0;
    end else begin
      if (out_free) begin
        // Spare entry drains first to keep order
        o_valid    <= skid_valid || i_valid;
        skid_valid <= 1'b0;
      end else if (to_skid) begin
        skid_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (out_free) begin
      if (skid_valid) begin
        o_data <= skid_data;
      end else if (i_valid) begin
        o_data <= i_data;
      end
    end
    if (to_skid) begin
      skid_data <= i_data;
    end
  end

  // A stalled output word must hold until taken
  a_hold_stalled: assert property (
    @(posedge clk) disable iff (i_rst)
    o_valid && !i_ready |=> o_valid && $stable(o_data)
  ) else $error("skid_buf: output changed while stalled");

endmodule

`default_nettype wire

/* src.f */
design/axi_pkg.sv
design/bridge_pkg.sv
design/id_fifo_if.sv
design/skid_buf.sv
design/id_fifo.sv
design/axi_axil_wr_ctrl.sv
design/axi_axil_wr_top.sv
bench/tb_axil_sub.sv
bench/tb_axi_axil_wr.sv
